/* files.f */
+incdir+.
mips_pkg.sv
mips_regfile.sv
mips_control.sv
mips_alu.sv
mips_pc_control.sv
mips_core.sv
mips_properties.sv
mips_tb.sv

/* mips_alu.sv */
`timescale 1ns/1ps
`include "mips_config.svh"

module mips_alu
    import mips_pkg::*;
(
    input  word_t     a,
    input  word_t     b,
    input  alu_ctrl_t alu_ctrl,
    output word_t     alu_result,
    output logic      zero
);

    localparam int HALF = `MIPS_XLEN / 2;

    logic [4:0] shamt;

    assign shamt = a[4:0];

    always_comb begin
        case (alu_ctrl)
            ALU_ADD:  alu_result = a + b;
            ALU_SUB:  alu_result = a - b;
            ALU_AND:  alu_result = a & b;
            ALU_OR:   alu_result = a | b;
            ALU_XOR:  alu_result = a ^ b;
            ALU_NOR:  alu_result = ~(a | b);
            ALU_SLT:  alu_result = word_t'($signed(a) < $signed(b));
            ALU_SLTU: alu_result = word_t'(a < b);
            ALU_SLL:  alu_result = b << shamt;
            ALU_SRL:  alu_result = b >> shamt;
            ALU_SRA:  alu_result = word_t'($signed(b) >>> shamt); // fills with the sign bit.
            ALU_LUI:  alu_result = {b[HALF-1:0], {HALF{1'b0}}};
            default:  alu_result = '0;
        endcase
    end

    // beq and bne look at this after a subtract.
    assign zero = (alu_result == '0);

endmodule

/* mips_config.svh */
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// data and address word width.
`define MIPS_XLEN 32

// first fetch address after reset.
`define MIPS_RESET_PC 32'h0000_0000

// R-type function code that stops the core.
`define MIPS_FUNC_SYSCALL 6'h0c

`endif

/* mips_control.sv */
`timescale 1ns/1ps
`include "mips_config.svh"

module mips_control
    import mips_pkg::*;
(
    input  opcode_t    opcode,
    input  func_t      func,
    output logic       reg_dst,
    output logic [1:0] alu_src,
    output logic       mem_to_reg,
    output logic       reg_write,
    output logic       mem_write,
    output logic [1:0] branch,
    output logic [1:0] jump,
    output logic       jr,
    output logic       do_extend,
    output alu_ctrl_t  alu_ctrl
);

    always_comb begin
        reg_dst    = 1'b0;
        alu_src    = 2'b00; // bit 0 picks shamt for a, bit 1 the immediate for b.
        mem_to_reg = 1'b0;
        reg_write  = 1'b0;
        mem_write  = 1'b0;
        branch     = BR_NONE;
        jump       = JMP_NONE;
        jr         = 1'b0;
        do_extend  = 1'b1;
        alu_ctrl   = ALU_ADD;

        case (opcode)
            OP_RTYPE: begin
                reg_dst   = 1'b1;
                reg_write = 1'b1;
                case (func)
                    FN_ADD, FN_ADDU: alu_ctrl = ALU_ADD;
                    FN_SUB, FN_SUBU: alu_ctrl = ALU_SUB;
                    FN_AND:  alu_ctrl = ALU_AND;
                    FN_OR:   alu_ctrl = ALU_OR;
                    FN_XOR:  alu_ctrl = ALU_XOR;
                    FN_NOR:  alu_ctrl = ALU_NOR;
                    FN_SLT:  alu_ctrl = ALU_SLT;
                    FN_SLTU: alu_ctrl = ALU_SLTU;
                    FN_SLL: begin
                        alu_src  = 2'b01;
                        alu_ctrl = ALU_SLL;
                    end
                    FN_SRL: begin
                        alu_src  = 2'b01;
                        alu_ctrl = ALU_SRL;
                    end
                    FN_SRA: begin
                        alu_src  = 2'b01;
                        alu_ctrl = ALU_SRA;
                    end
                    FN_JR: begin
                        reg_write = 1'b0;
                        jr        = 1'b1;
                    end
                    `MIPS_FUNC_SYSCALL: reg_write = 1'b0; // the core stops here.
                    default: reg_write = 1'b0;
                endcase
            end
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_LW: begin
                alu_src    = 2'b10;
                reg_write  = 1'b1;
                mem_to_reg = (opcode == OP_LW);
                alu_ctrl   = (opcode == OP_SLTI) ? ALU_SLT : ALU_ADD;
            end
            OP_ANDI, OP_ORI, OP_XORI: begin
                alu_src   = 2'b10;
                reg_write = 1'b1;
                do_extend = 1'b0; // logical immediates are zero-extended.
                case (opcode)
                    OP_ANDI: alu_ctrl = ALU_AND;
                    OP_ORI:  alu_ctrl = ALU_OR;
                    default: alu_ctrl = ALU_XOR;
                endcase
            end
            OP_LUI: begin
                alu_src   = 2'b10;
                reg_write = 1'b1;
                alu_ctrl  = ALU_LUI;
            end
            OP_SW: begin
                alu_src   = 2'b10;
                mem_write = 1'b1;
            end
            OP_BEQ: begin
                branch   = BR_BEQ;
                alu_ctrl = ALU_SUB;
            end
            OP_BNE: begin
                branch   = BR_BNE;
                alu_ctrl = ALU_SUB;
            end
            OP_J:   jump = JMP_J;
            OP_JAL: begin
                jump      = JMP_JAL;
                reg_write = 1'b1; // link goes to register 31.
            end
            default: ;
        endcase
    end

endmodule

/* mips_core.sv */
`timescale 1ns/1ps
`include "mips_config.svh"

module mips_core
    import mips_pkg::*;
(
    input  logic  clk,
    input  logic  rst_b,
    output word_t inst_addr,
    input  word_t inst,
    output word_t mem_addr,
    input  byte_t mem_data_out [0:3],
    output byte_t mem_data_in [0:3],
    output logic  mem_write_en,
    output logic  halted
);

    opcode_t     opcode;
    func_t       func;
    reg_num_t    rs_num;
    reg_num_t    rt_num;
    reg_num_t    rd_num;
    logic [4:0]  sh_amount;
    logic [15:0] immediate_data;
    logic [25:0] address;
    word_t       sign_extend_immediate;

    logic        reg_dst;
    logic [1:0]  alu_src;
    logic        mem_to_reg;
    logic        reg_write;
    logic        mem_write;
    logic [1:0]  branch;
    logic [1:0]  jump;
    logic        jr;
    logic        do_extend;
    alu_ctrl_t   alu_ctrl;

    word_t       rs_data;
    word_t       rt_data;
    word_t       rd_data;
    word_t       a;
    word_t       b;
    word_t       alu_result;
    logic        zero;
    word_t       load_word;
    word_t       pc;
    word_t       pc_plus4;
    word_t       next_pc;
    logic        halt;
    logic        commit;

    assign opcode         = inst[31:26];
    assign rs_num         = inst[25:21];
    assign rt_num         = inst[20:16];
    assign sh_amount      = inst[10:6];
    assign func           = inst[5:0];
    assign immediate_data = inst[15:0];
    assign address        = inst[25:0];

    assign sign_extend_immediate = do_extend ? word_t'($signed(immediate_data))
                                             : word_t'(immediate_data);

    assign a = alu_src[0] ? word_t'(sh_amount) : rs_data;
    assign b = alu_src[1] ? sign_extend_immediate : rt_data;

    assign rd_num = reg_dst ? inst[15:11] : (jump == JMP_JAL) ? reg_num_t'(31) : rt_num;

    assign load_word = {mem_data_out[3], mem_data_out[2], mem_data_out[1], mem_data_out[0]};
    assign pc_plus4  = pc + word_t'(4); // no delay slot, so jal links to pc+4.

    assign rd_data = mem_to_reg ? load_word : (jump == JMP_JAL) ? pc_plus4 : alu_result;

    assign halt   = rst_b && (opcode == OP_RTYPE) && (func == `MIPS_FUNC_SYSCALL);
    assign commit = rst_b && !halt; // state changes only on a live, running cycle.

    assign halted       = halt;
    assign inst_addr    = pc;
    assign mem_addr     = alu_result;
    assign mem_write_en = mem_write && commit;

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            mem_data_in[i] = rt_data[8*i +: 8]; // lane 0 is the low byte.
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_b) begin
            pc <= `MIPS_RESET_PC;
        end else if (!halt) begin
            pc <= next_pc;
        end
    end

    mips_regfile mips_regfile_inst (
        .clk     (clk),
        .rst_b   (rst_b),
        .rs_num  (rs_num),
        .rt_num  (rt_num),
        .rd_num  (rd_num),
        .rd_data (rd_data),
        .rd_we   (reg_write && commit),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

    mips_control mips_control_inst (
        .opcode     (opcode),
        .func       (func),
        .reg_dst    (reg_dst),
        .alu_src    (alu_src),
        .mem_to_reg (mem_to_reg),
        .reg_write  (reg_write),
        .mem_write  (mem_write),
        .branch     (branch),
        .jump       (jump),
        .jr         (jr),
        .do_extend  (do_extend),
        .alu_ctrl   (alu_ctrl)
    );

    mips_alu mips_alu_inst (
        .a          (a),
        .b          (b),
        .alu_ctrl   (alu_ctrl),
        .alu_result (alu_result),
        .zero       (zero)
    );

    mips_pc_control mips_pc_control_inst (
        .pc                    (pc),
        .address               (address),
        .sign_extend_immediate (sign_extend_immediate),
        .rs_data               (rs_data),
        .zero                  (zero),
        .branch                (branch),
        .jump                  (jump),
        .jr                    (jr),
        .next_pc               (next_pc)
    );

endmodule

/* mips_pc_control.sv */
`timescale 1ns/1ps
`include "mips_config.svh"

module mips_pc_control
    import mips_pkg::*;
(
    input  word_t       pc,
    input  logic [25:0] address,
    input  word_t       sign_extend_immediate,
    input  word_t       rs_data,
    input  logic        zero,
    input  logic [1:0]  branch,
    input  logic [1:0]  jump,
    input  logic        jr,
    output word_t       next_pc
);

    word_t pc_plus4;
    word_t branch_target;
    word_t jump_target;
    logic  taken;

    assign pc_plus4      = pc + word_t'(4);
    assign branch_target = pc_plus4 + (sign_extend_immediate << 2);
    assign jump_target   = {pc_plus4[`MIPS_XLEN-1:28], address, 2'b00};

    assign taken = ((branch == BR_BEQ) && zero) || ((branch == BR_BNE) && !zero);

    always_comb begin
        if (jr) begin
            next_pc = rs_data;
        end else if (jump != JMP_NONE) begin
            next_pc = jump_target;
        end else if (taken) begin
            next_pc = branch_target;
        end else begin
            next_pc = pc_plus4;
        end
    end

endmodule

/* mips_pkg.sv */
`include "mips_config.svh"

package mips_pkg;

    typedef logic [`MIPS_XLEN-1:0] word_t;
    typedef logic [4:0]            reg_num_t;
    typedef logic [5:0]            opcode_t;
    typedef logic [5:0]            func_t;
    typedef logic [3:0]            alu_ctrl_t;
    typedef logic [7:0]            byte_t;

    localparam alu_ctrl_t ALU_ADD  = 4'd0;
    localparam alu_ctrl_t ALU_SUB  = 4'd1;
    localparam alu_ctrl_t ALU_AND  = 4'd2;
    localparam alu_ctrl_t ALU_OR   = 4'd3;
    localparam alu_ctrl_t ALU_XOR  = 4'd4;
    localparam alu_ctrl_t ALU_NOR  = 4'd5;
    localparam alu_ctrl_t ALU_SLT  = 4'd6;
    localparam alu_ctrl_t ALU_SLTU = 4'd7;
    localparam alu_ctrl_t ALU_SLL  = 4'd8;
    localparam alu_ctrl_t ALU_SRL  = 4'd9;
    localparam alu_ctrl_t ALU_SRA  = 4'd10;
    localparam alu_ctrl_t ALU_LUI  = 4'd11;

    localparam opcode_t OP_RTYPE = 6'h00;
    localparam opcode_t OP_J     = 6'h02;
    localparam opcode_t OP_JAL   = 6'h03;
    localparam opcode_t OP_BEQ   = 6'h04;
    localparam opcode_t OP_BNE   = 6'h05;
    localparam opcode_t OP_ADDI  = 6'h08;
    localparam opcode_t OP_ADDIU = 6'h09;
    localparam opcode_t OP_SLTI  = 6'h0a;
    localparam opcode_t OP_ANDI  = 6'h0c;
    localparam opcode_t OP_ORI   = 6'h0d;
    localparam opcode_t OP_XORI  = 6'h0e;
    localparam opcode_t OP_LUI   = 6'h0f;
    localparam opcode_t OP_LW    = 6'h23;
    localparam opcode_t OP_SW    = 6'h2b;

    localparam func_t FN_SLL  = 6'h00;
    localparam func_t FN_SRL  = 6'h02;
    localparam func_t FN_SRA  = 6'h03;
    localparam func_t FN_JR   = 6'h08;
    localparam func_t FN_ADD  = 6'h20;
    localparam func_t FN_ADDU = 6'h21;
    localparam func_t FN_SUB  = 6'h22;
    localparam func_t FN_SUBU = 6'h23;
    localparam func_t FN_AND  = 6'h24;
    localparam func_t FN_OR   = 6'h25;
    localparam func_t FN_XOR  = 6'h26;
    localparam func_t FN_NOR  = 6'h27;
    localparam func_t FN_SLT  = 6'h2a;
    localparam func_t FN_SLTU = 6'h2b;

    // branch and jump select encodings between decoder and next-PC logic.
    localparam logic [1:0] BR_NONE  = 2'd0;
    localparam logic [1:0] BR_BEQ   = 2'd1;
    localparam logic [1:0] BR_BNE   = 2'd2;
    localparam logic [1:0] JMP_NONE = 2'd0;
    localparam logic [1:0] JMP_J    = 2'd1;
    localparam logic [1:0] JMP_JAL  = 2'd2;

endpackage

/* mips_properties.sv */
`timescale 1ns/1ps

module mips_properties
    import mips_pkg::*;
(
    input logic  clk,
    input logic  rst_b,
    input word_t inst_addr,
    input word_t mem_addr,
    input logic  mem_write_en,
    input logic  halted
);

    int failures = 0;

    fetch_aligned: assert property (@(posedge clk) disable iff (!rst_b)
        inst_addr[1:0] == 2'b00)
    else begin
        failures++;
        $error("inst_addr %h is not word aligned", inst_addr);
    end

    // no store and no halt in reset, nor in the first cycle after it.
    quiet_in_reset: assert property (@(posedge clk)
        !rst_b |-> (!mem_write_en && !halted) ##1 (!mem_write_en && !halted))
    else begin
        failures++;
        $error("mem_write_en or halted active around reset");
    end

    halt_holds: assert property (@(posedge clk) disable iff (!rst_b)
        halted |-> !mem_write_en ##1 (halted && $stable(inst_addr)))
    else begin
        failures++;
        $error("core did not stay halted, inst_addr %h", inst_addr);
    end

    store_aligned: assert property (@(posedge clk) disable iff (!rst_b)
        mem_write_en |-> mem_addr[1:0] == 2'b00)
    else begin
        failures++;
        $error("store to unaligned mem_addr %h", mem_addr);
    end

endmodule

bind mips_core mips_properties mips_properties_inst (
    .clk          (clk),
    .rst_b        (rst_b),
    .inst_addr    (inst_addr),
    .mem_addr     (mem_addr),
    .mem_write_en (mem_write_en),
    .halted       (halted)
);

/* mips_regfile.sv */
`timescale 1ns/1ps

module mips_regfile
    import mips_pkg::*;
(
    input  logic     clk,
    input  logic     rst_b,
    input  reg_num_t rs_num,
    input  reg_num_t rt_num,
    input  reg_num_t rd_num,
    input  word_t    rd_data,
    input  logic     rd_we,
    output word_t    rs_data,
    output word_t    rt_data
);

    word_t regs [1:31]; // register 0 has no storage.

    always_ff @(posedge clk) begin
        if (!rst_b) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_we && (rd_num != '0)) begin
            regs[rd_num] <= rd_data;
        end
    end

    always_comb begin
        if (rs_num == '0) begin
            rs_data = '0;
        end else begin
            rs_data = regs[rs_num];
        end
        if (rt_num == '0) begin
            rt_data = '0;
        end else begin
            rt_data = regs[rt_num];
        end
    end

endmodule

/* mips_tb.sv */
`timescale 1ns/1ps
`include "mips_config.svh"

module mips_tb
    import mips_pkg::*;
();

    localparam int CLK_PERIOD     = 8;
    localparam int DRIVE_DELAY    = 1;
    localparam int RESET_CYCLES   = 3;
    localparam int MID_RUN_CYCLES = 20;
    localparam int HOLD_CYCLES    = 4;

    logic  clk;
    logic  rst_b;
    word_t inst_addr;
    word_t inst;
    word_t mem_addr;
    byte_t load_lanes [0:3];
    byte_t store_lanes [0:3];
    logic  mem_write_en;
    logic  halted;

    word_t rom [0:255];
    byte_t ram [0:255][0:3];
    word_t expect_mem [0:255];
    logic  ram_fill;
    int    prog_len;
    int    watchdog_cycles;

    mips_core mips_core_inst (
        .clk          (clk),
        .rst_b        (rst_b),
        .inst_addr    (inst_addr),
        .inst         (inst),
        .mem_addr     (mem_addr),
        .mem_data_out (load_lanes),
        .mem_data_in  (store_lanes),
        .mem_write_en (mem_write_en),
        .halted       (halted)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // each RAM word starts with a value unique to its address.
    function automatic word_t fill_word(int idx);
        return {8'h5a, 8'(idx), 8'(~idx), 8'(idx ^ 8'h3c)};
    endfunction

    // two's complement order: a differing sign bit decides, else the magnitudes do.
    function automatic word_t signed_less(word_t x, word_t y);
        if (x[31] != y[31]) begin
            return word_t'(x[31]);
        end
        return word_t'(x < y);
    endfunction

    assign inst = rom[8'((inst_addr - `MIPS_RESET_PC) >> 2)];

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            load_lanes[i] = ram[mem_addr[9:2]][i];
        end
    end

    always @(posedge clk) begin
        if (ram_fill) begin
            for (int w = 0; w < 256; w++) begin
                for (int i = 0; i < 4; i++) begin
                    ram[w][i] <= 8'(fill_word(w) >> (8 * i));
                end
            end
        end else if (mem_write_en === 1'b1) begin
            for (int i = 0; i < 4; i++) begin
                ram[mem_addr[9:2]][i] <= store_lanes[i];
            end
        end
    end

    function automatic word_t rtype_word(func_t fn, reg_num_t rd, reg_num_t rs, reg_num_t rt,
                                         logic [4:0] sh);
        return {OP_RTYPE, rs, rt, rd, sh, fn};
    endfunction

    function automatic word_t itype_word(opcode_t op, reg_num_t rt, reg_num_t rs,
                                         logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t jump_word(opcode_t op, int index);
        word_t target;
        target = `MIPS_RESET_PC + word_t'(4 * index);
        return {op, target[27:2]};
    endfunction

    task automatic emit(word_t w);
        rom[prog_len] = w;
        prog_len++;
    endtask

    task automatic load_const(reg_num_t r, word_t value);
        emit(itype_word(OP_LUI, r, 5'd0, value[31:16]));
        emit(itype_word(OP_ORI, r, r, value[15:0]));
    endtask

    task automatic store_slot(reg_num_t r, int slot, word_t value);
        emit(itype_word(OP_SW, r, 5'd0, 16'(4 * slot)));
        expect_mem[slot] = value;
    endtask

    task automatic reg_op(func_t fn, int slot, word_t value);
        emit(rtype_word(fn, 5'd4, 5'd1, 5'd2, 5'd0));
        store_slot(5'd4, slot, value);
    endtask

    task automatic imm_op(opcode_t op, logic [15:0] imm, int slot, word_t value);
        emit(itype_word(op, 5'd4, 5'd1, imm));
        store_slot(5'd4, slot, value);
    endtask

    task automatic shift_op(func_t fn, logic [4:0] sh, int slot, word_t value);
        emit(rtype_word(fn, 5'd4, 5'd0, 5'd1, sh));
        store_slot(5'd4, slot, value);
    endtask

    // the marker store is skipped when the branch is taken.
    task automatic branch_case(opcode_t op, reg_num_t rs, reg_num_t rt, int slot, bit taken);
        emit(itype_word(op, rt, rs, 16'd2));
        emit(itype_word(OP_ORI, 5'd6, 5'd0, 16'(16'hb000 + slot)));
        emit(itype_word(OP_SW, 5'd6, 5'd0, 16'(4 * slot)));
        if (!taken) begin
            expect_mem[slot] = 32'h0000_b000 + word_t'(slot);
        end
    endtask

    task automatic reset_core();
        @(posedge clk);
        #(DRIVE_DELAY);
        rst_b    = 1'b0;
        ram_fill = 1'b1;
        @(posedge clk);
        #(DRIVE_DELAY);
        ram_fill = 1'b0;
        repeat (RESET_CYCLES - 1) @(posedge clk);
        #(DRIVE_DELAY);
        rst_b = 1'b1;
        @(negedge clk);
        assert (halted === 1'b0) else begin
            $display("Error: halted after reset expected %h, got %h", 1'b0, halted);
            $display("Done: errors found");
            $fatal(1);
        end
    endtask

    task automatic wait_halt();
        do begin
            @(negedge clk);
        end while (halted !== 1'b1);
        repeat (HOLD_CYCLES) @(posedge clk); // lets the halt properties see a held PC.
    endtask

    task automatic check_ram();
        word_t got;
        for (int i = 0; i < 256; i++) begin
            got = {ram[i][3], ram[i][2], ram[i][1], ram[i][0]};
            assert (got === expect_mem[i]) else begin
                $display("Error: ram[%0d] expected %h, got %h", i, expect_mem[i], got);
                $display("Done: errors found");
                $fatal(1);
            end
        end
    endtask

    always @(mips_core_inst.mips_properties_inst.failures) begin
        if (mips_core_inst.mips_properties_inst.failures != 0) begin
            $display("A property on the core ports failed.");
            $display("Done: errors found");
            $fatal(1);
        end
    end

    initial begin
        #(DRIVE_DELAY);
        repeat (watchdog_cycles) @(posedge clk);
        $display("Timeout: the core did not finish within %0d cycles.", watchdog_cycles);
        $display("Done: errors found");
        $fatal(1);
    end

    initial begin
        word_t       opa;
        word_t       opb;
        logic [15:0] imm;
        logic [15:0] lui_imm;
        word_t       sext;
        word_t       zext;
        logic [4:0]  sh_l;
        logic [4:0]  sh_r;
        logic [4:0]  sh_a;
        int          jal_at;

        void'($urandom(37263));
        rst_b    = 1'b0;
        ram_fill = 1'b0;
        opa      = $urandom() | 32'h8000_0000; // negative, so slt and sltu disagree.
        opb      = $urandom() & 32'h7fff_ffff;
        imm      = 16'($urandom()) | 16'h8000; // bit 15 set, so sign and zero extension differ.
        lui_imm  = 16'($urandom());
        sh_l     = 5'($urandom());
        sh_r     = 5'($urandom());
        sh_a     = 5'($urandom() % 31 + 1); // never zero, so the sign fill shows.
        sext     = {{16{imm[15]}}, imm};
        zext     = {16'h0000, imm};

        for (int i = 0; i < 256; i++) begin
            rom[i]        = rtype_word(`MIPS_FUNC_SYSCALL, 5'd0, 5'd0, 5'd0, 5'd0);
            expect_mem[i] = fill_word(i);
        end
        prog_len = 0;
        load_const(5'd1, opa);
        load_const(5'd2, opb);
        reg_op(FN_ADD, 0, opa + opb);
        reg_op(FN_ADDU, 1, opa + opb);
        reg_op(FN_SUB, 2, opa - opb);
        reg_op(FN_SUBU, 3, opa - opb);
        reg_op(FN_AND, 4, opa & opb);
        reg_op(FN_OR, 5, opa | opb);
        reg_op(FN_XOR, 6, opa ^ opb);
        reg_op(FN_NOR, 7, ~(opa | opb));
        reg_op(FN_SLT, 8, signed_less(opa, opb));
        reg_op(FN_SLTU, 9, word_t'(opa < opb));
        imm_op(OP_ADDI, imm, 10, opa + sext);
        imm_op(OP_ADDIU, imm, 11, opa + sext);
        imm_op(OP_ANDI, imm, 12, opa & zext);
        imm_op(OP_ORI, imm, 13, opa | zext);
        imm_op(OP_XORI, imm, 14, opa ^ zext);
        imm_op(OP_SLTI, imm, 15, signed_less(opa, sext));
        shift_op(FN_SLL, sh_l, 16, opa << sh_l);
        shift_op(FN_SRL, sh_r, 17, opa >> sh_r);
        shift_op(FN_SRA, sh_a, 18,
                 (opa >> sh_a) | (opa[31] ? ~(32'hffff_ffff >> sh_a) : 32'h0));
        emit(itype_word(OP_LUI, 5'd4, 5'd0, lui_imm));
        store_slot(5'd4, 19, {lui_imm, 16'h0000});
        store_slot(5'd1, 20, opa);
        emit(itype_word(OP_LW, 5'd5, 5'd0, 16'(4 * 20)));
        store_slot(5'd5, 21, opa);
        emit(itype_word(OP_ADDI, 5'd0, 5'd1, 16'h0005)); // register 0 must stay zero.
        store_slot(5'd0, 22, 32'h0000_0000);
        branch_case(OP_BEQ, 5'd1, 5'd1, 23, 1'b1);
        branch_case(OP_BEQ, 5'd1, 5'd2, 24, 1'b0);
        branch_case(OP_BNE, 5'd1, 5'd2, 25, 1'b1);
        branch_case(OP_BNE, 5'd1, 5'd1, 26, 1'b0);
        emit(jump_word(OP_J, prog_len + 3));
        emit(itype_word(OP_ORI, 5'd6, 5'd0, 16'hbad0));
        emit(itype_word(OP_SW, 5'd6, 5'd0, 16'(4 * 27)));
        jal_at = prog_len;
        emit(jump_word(OP_JAL, jal_at + 4));
        emit(itype_word(OP_ORI, 5'd6, 5'd0, 16'hc0de)); // reached again through jr.
        store_slot(5'd6, 28, 32'h0000_c0de);
        emit(jump_word(OP_J, jal_at + 6));
        store_slot(5'd31, 29, `MIPS_RESET_PC + word_t'(4 * (jal_at + 1)));
        emit(rtype_word(FN_JR, 5'd0, 5'd31, 5'd0, 5'd0));
        emit(rtype_word(`MIPS_FUNC_SYSCALL, 5'd0, 5'd0, 5'd0, 5'd0));
        watchdog_cycles = 2 * (2 * prog_len + 2 * HOLD_CYCLES + 3 * (RESET_CYCLES + 2)
                               + MID_RUN_CYCLES);

        reset_core();
        wait_halt();
        check_ram();
        reset_core();
        repeat (MID_RUN_CYCLES) @(posedge clk);
        reset_core(); // cuts the rerun short and starts it over.
        wait_halt();
        check_ram();

        if (mips_core_inst.mips_properties_inst.failures == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            $display("Done: errors found");
            $fatal(1);
        end
    end

endmodule
